// File: logic/rv32_ctrl_pkg.sv
// RV32I control decoder package with field encodings, control word and lookup key types
package rv32_ctrl_pkg;

    localparam int unsigned inst_w = 32;              // Instruction width
    localparam logic [6:0]  funct7_zero = 7'b0000000; // Base funct7
    localparam logic [6:0]  funct7_alt  = 7'b0100000; // Selects sub and sra

    // Major opcodes decoded by the table
    typedef enum logic [6:0] {
        op_load   = 7'b0000011, // I-type loads
        op_imm    = 7'b0010011, // ALU immediate
        op_auipc  = 7'b0010111, // U-type
        op_store  = 7'b0100011, // S-type
        op_reg    = 7'b0110011, // R-type
        op_lui    = 7'b0110111, // U-type
        op_branch = 7'b1100011, // B-type
        op_jalr   = 7'b1100111, // I-type jump
        op_jal    = 7'b1101111  // J-type
    } opcode_e;

    typedef enum logic [4:0] {
        alu_add  = 5'd0,
        alu_sub  = 5'd1,
        alu_slt  = 5'd2,
        alu_sltu = 5'd3,
        alu_xor  = 5'd4,
        alu_or   = 5'd5,
        alu_and  = 5'd6,
        alu_sll  = 5'd7,
        alu_srl  = 5'd8,
        alu_sra  = 5'd9,
        alu_lui  = 5'd10 // Passes the immediate
    } alu_op_e;

    typedef enum logic [1:0] {
        op1_rs1 = 2'd0,
        op1_pc  = 2'd1
    } op1_sel_e;

    typedef enum logic [1:0] {
        op2_none      = 2'd0, // No second operand
        op2_imm       = 2'd1, // I-type immediate
        op2_store_imm = 2'd2, // S-type split immediate
        op2_rs2       = 2'd3
    } op2_sel_e;

    typedef enum logic [2:0] {
        pc_seq    = 3'd0, // PC + 4
        pc_jalr   = 3'd1,
        pc_branch = 3'd2, // Taken branch target
        pc_jal    = 3'd3
    } pc_sel_e;

    typedef enum logic [1:0] {
        wb_none = 2'd0,
        wb_pc4  = 2'd1, // Link address
        wb_alu  = 2'd2,
        wb_mem  = 2'd3  // Load data
    } wb_sel_e;

    // Access width, same code as the load/store funct3
    typedef enum logic [2:0] {
        mw_byte   = 3'd0,
        mw_half   = 3'd1,
        mw_word   = 3'd2,
        mw_byte_u = 3'd4,
        mw_half_u = 3'd5
    } mem_width_e;

    // Lookup key, 17 bits
    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
    } inst_key_t;

    // Compare flags from execute
    typedef struct packed {
        logic eq;  // rs1 == rs2
        logic lt;  // Signed rs1 < rs2
        logic ltu; // Unsigned rs1 < rs2
    } br_flags_t;

    // Decoded control word, 20 bits
    typedef struct packed {
        alu_op_e    alu_op;
        op1_sel_e   op1_sel;
        op2_sel_e   op2_sel;
        pc_sel_e    pc_sel;
        logic       rf_we;     // Register file write
        logic       mem_en;    // Memory access
        logic       mem_wen;   // Memory write
        wb_sel_e    wb_sel;
        mem_width_e mem_width; // Zero outside loads and stores
    } ctrl_word_t;

endpackage

// File: logic/inst_key_former.sv
// Instruction key former, masks the fields each format leaves unspecified
`timescale 1ns/1ps

module inst_key_former import rv32_ctrl_pkg::*; (
    input  logic [inst_w-1:0] inst,
    output inst_key_t         key
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(inst[6:0]); // May hold a value outside the enum
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        key.opcode = opcode;
        key.funct3 = funct3;
        key.funct7 = funct7; // Full key unless cleared below
        case (opcode)
            op_jalr: begin
                if (funct3 == 3'b000) begin
                    key.funct7 = funct7_zero; // Imm bits, not funct7
                end
            end
            op_imm: begin
                if (funct3 != 3'b101) begin
                    key.funct7 = funct7_zero; // Only srli/srai use funct7
                end
            end
            op_auipc, op_lui, op_jal: begin
                key.funct3 = 3'b000; // Whole upper field is immediate
                key.funct7 = funct7_zero;
            end
            op_store, op_load, op_branch: begin
                key.funct7 = funct7_zero; // Immediate bits
            end
            default: begin
                // Unknown opcodes keep every field so they miss the table
                key.funct7 = funct7;
            end
        endcase
    end

endmodule

// File: logic/ctrl_lut.sv
// Control table, maps the instruction key to a control word and access width
`timescale 1ns/1ps

module ctrl_lut import rv32_ctrl_pkg::*; (
    input  inst_key_t  key,
    output ctrl_word_t ctrl
);

    ctrl_word_t base;  // Table word before width merge
    mem_width_e width; // From opcode and funct3

    // Builds one table row, width added later
    function automatic ctrl_word_t row(
        input alu_op_e  alu_op,
        input op1_sel_e op1_sel,
        input op2_sel_e op2_sel,
        input pc_sel_e  pc_sel,
        input logic     rf_we,
        input logic     mem_en,
        input logic     mem_wen,
        input wb_sel_e  wb_sel
    );
        ctrl_word_t w;
        w.alu_op    = alu_op;
        w.op1_sel   = op1_sel;
        w.op2_sel   = op2_sel;
        w.pc_sel    = pc_sel;
        w.rf_we     = rf_we;
        w.mem_en    = mem_en;
        w.mem_wen   = mem_wen;
        w.wb_sel    = wb_sel;
        w.mem_width = mw_byte;
        return w;
    endfunction

    always_comb begin
        base = '0; // Miss gives all-zero word
        case (key)
            {op_reg, 3'b000, funct7_zero}: // ADD
                base = row(alu_add, op1_rs1, op2_rs2, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_reg, 3'b000, funct7_alt}: // SUB
                base = row(alu_sub, op1_rs1, op2_rs2, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_reg, 3'b001, funct7_zero}: // SLL
                base = row(alu_sll, op1_rs1, op2_rs2, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_reg, 3'b010, funct7_zero}: // SLT
                base = row(alu_slt, op1_rs1, op2_rs2, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_reg, 3'b011, funct7_zero}: // SLTU
                base = row(alu_sltu, op1_rs1, op2_rs2, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_reg, 3'b100, funct7_zero}: // XOR
                base = row(alu_xor, op1_rs1, op2_rs2, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_reg, 3'b101, funct7_zero}: // SRL
                base = row(alu_srl, op1_rs1, op2_rs2, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_reg, 3'b101, funct7_alt}: // SRA
                base = row(alu_sra, op1_rs1, op2_rs2, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_reg, 3'b110, funct7_zero}: // OR
                base = row(alu_or, op1_rs1, op2_rs2, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_reg, 3'b111, funct7_zero}: // AND
                base = row(alu_and, op1_rs1, op2_rs2, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_imm, 3'b000, funct7_zero}: // ADDI
                base = row(alu_add, op1_rs1, op2_imm, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_imm, 3'b010, funct7_zero}: // SLTI
                base = row(alu_slt, op1_rs1, op2_imm, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_imm, 3'b011, funct7_zero}: // SLTIU
                base = row(alu_sltu, op1_rs1, op2_imm, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_imm, 3'b100, funct7_zero}: // XORI
                base = row(alu_xor, op1_rs1, op2_imm, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_imm, 3'b110, funct7_zero}: // ORI
                base = row(alu_or, op1_rs1, op2_imm, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_imm, 3'b111, funct7_zero}: // ANDI
                base = row(alu_and, op1_rs1, op2_imm, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_imm, 3'b001, funct7_zero}: // SLLI
                base = row(alu_sll, op1_rs1, op2_imm, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_imm, 3'b101, funct7_zero}: // SRLI
                base = row(alu_srl, op1_rs1, op2_imm, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_imm, 3'b101, funct7_alt}: // SRAI
                base = row(alu_sra, op1_rs1, op2_imm, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_load, 3'b010, funct7_zero}, // LW
            {op_load, 3'b000, funct7_zero}, // LB
            {op_load, 3'b100, funct7_zero}, // LBU
            {op_load, 3'b001, funct7_zero}, // LH
            {op_load, 3'b101, funct7_zero}: // LHU
                base = row(alu_add, op1_rs1, op2_imm, pc_seq, 1'b1, 1'b1, 1'b0, wb_mem);
            {op_branch, 3'b000, funct7_zero}, // BEQ
            {op_branch, 3'b001, funct7_zero}, // BNE
            {op_branch, 3'b100, funct7_zero}, // BLT
            {op_branch, 3'b101, funct7_zero}, // BGE
            {op_branch, 3'b110, funct7_zero}, // BLTU
            {op_branch, 3'b111, funct7_zero}: // BGEU, pc_sel resolved downstream
                base = row(alu_add, op1_rs1, op2_none, pc_seq, 1'b0, 1'b0, 1'b0, wb_alu);
            {op_jal, 3'b000, funct7_zero}: // JAL
                base = row(alu_add, op1_rs1, op2_none, pc_jal, 1'b1, 1'b0, 1'b0, wb_pc4);
            {op_auipc, 3'b000, funct7_zero}: // AUIPC
                base = row(alu_add, op1_pc, op2_none, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_lui, 3'b000, funct7_zero}: // LUI
                base = row(alu_lui, op1_pc, op2_none, pc_seq, 1'b1, 1'b0, 1'b0, wb_alu);
            {op_store, 3'b010, funct7_zero}, // SW
            {op_store, 3'b000, funct7_zero}, // SB
            {op_store, 3'b001, funct7_zero}: // SH
                base = row(alu_add, op1_rs1, op2_store_imm, pc_seq, 1'b0, 1'b1, 1'b1, wb_none);
            {op_jalr, 3'b000, funct7_zero}: // JALR
                base = row(alu_add, op1_rs1, op2_imm, pc_jalr, 1'b1, 1'b0, 1'b0, wb_pc4);
            default: base = '0;
        endcase
    end

    // Access width table, 5 loads and 3 stores
    always_comb begin
        width = mw_byte; // Zero for everything else
        case ({key.opcode, key.funct3})
            {op_load, 3'b010}:  width = mw_word;
            {op_load, 3'b000}:  width = mw_byte;
            {op_load, 3'b100}:  width = mw_byte_u;
            {op_load, 3'b001}:  width = mw_half;
            {op_load, 3'b101}:  width = mw_half_u;
            {op_store, 3'b010}: width = mw_word;
            {op_store, 3'b000}: width = mw_byte;
            {op_store, 3'b001}: width = mw_half;
            default:            width = mw_byte;
        endcase
    end

    always_comb begin
        ctrl           = base;
        ctrl.mem_width = width; // Merge width into table word
    end

    // Every table write row also enables memory
    always_comb begin
        assert (!ctrl.mem_wen || ctrl.mem_en)
            else $error("ctrl_lut: mem_wen without mem_en, key %h", key);
    end

endmodule

// File: logic/branch_resolve.sv
// Branch resolver, sets the next-PC select of conditional branches from the compare flags
`timescale 1ns/1ps

module branch_resolve import rv32_ctrl_pkg::*; (
    input  opcode_e    opcode,
    input  logic [2:0] funct3,
    input  br_flags_t  br,
    input  ctrl_word_t ctrl_in,
    output ctrl_word_t ctrl
);

    logic taken; // Branch condition holds

    always_comb begin
        case (funct3)
            3'b000:  taken = br.eq;   // BEQ
            3'b001:  taken = !br.eq;  // BNE
            3'b100:  taken = br.lt;   // BLT
            3'b101:  taken = !br.lt;  // BGE
            3'b110:  taken = br.ltu;  // BLTU
            3'b111:  taken = !br.ltu; // BGEU
            default: taken = 1'b0;    // Not a branch funct3
        endcase
    end

    always_comb begin
        ctrl = ctrl_in; // Other fields pass through
        if (opcode == op_branch) begin
            ctrl.pc_sel = taken ? pc_branch : pc_seq;
        end
    end

    // Table never yields a branch target, so only this stage can
    always_comb begin
        assert (ctrl.pc_sel != pc_branch || opcode == op_branch)
            else $error("branch_resolve: branch target on opcode %h", opcode);
    end

endmodule

// File: logic/ctrl_decode_top.sv
// Registered RV32I control decoder, key former, table and branch resolve with one output stage
`timescale 1ns/1ps

module ctrl_decode_top import rv32_ctrl_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  logic [inst_w-1:0] inst,
    input  br_flags_t         br,
    output logic              out_valid,
    output ctrl_word_t        ctrl
);

    inst_key_t  key;       // Masked lookup key
    ctrl_word_t lut_ctrl;  // Table word, pc_sel unresolved
    ctrl_word_t ctrl_next; // Final word before register

    inst_key_former inst_key_former_inst (
        .inst (inst),
        .key  (key)
    );

    ctrl_lut ctrl_lut_inst (
        .key  (key),
        .ctrl (lut_ctrl)
    );

    // Branch opcode and funct3 survive the key masking
    branch_resolve branch_resolve_inst (
        .opcode  (key.opcode),
        .funct3  (key.funct3),
        .br      (br),
        .ctrl_in (lut_ctrl),
        .ctrl    (ctrl_next)
    );

    // Single output stage, no stall
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            ctrl      <= '0;
        end else begin
            out_valid <= in_valid; // Follows input one cycle later
            if (in_valid) begin
                ctrl <= ctrl_next; // Holds on idle cycles
            end
        end
    end

    // Nothing valid leaves the stage right after reset
    assert property (@(posedge clk) rst |=> !out_valid)
        else $error("ctrl_decode_top: out_valid high after reset");

endmodule

// File: bench/ctrl_ref_model.svh
// Reference model of the RV32I control decoder, expected control word per instruction
`ifndef CTRL_REF_MODEL_SVH
`define CTRL_REF_MODEL_SVH

// ALU operation of register and immediate arithmetic
function automatic alu_op_e alu_for_funct3(input logic [2:0] funct3, input logic alt);
    case (funct3)
        3'b000: begin
            if (alt) begin
                return alu_sub;
            end
            return alu_add;
        end
        3'b001: return alu_sll;
        3'b010: return alu_slt;
        3'b011: return alu_sltu;
        3'b100: return alu_xor;
        3'b101: begin
            if (alt) begin
                return alu_sra;
            end
            return alu_srl;
        end
        3'b110: return alu_or;
        default: return alu_and;
    endcase
endfunction

function automatic ctrl_word_t expected_ctrl(input logic [31:0] inst, input br_flags_t br);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       taken;
    ctrl_word_t w;
    opcode = inst[6:0];
    funct3 = inst[14:12];
    funct7 = inst[31:25];
    w      = '0; // Anything unknown stays all zero
    case (opcode)
        op_reg: begin
            if (funct7 == funct7_zero ||
                (funct7 == funct7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                w.alu_op  = alu_for_funct3(funct3, funct7 == funct7_alt);
                w.op2_sel = op2_rs2;
                w.rf_we   = 1'b1;
                w.wb_sel  = wb_alu;
            end
        end
        op_imm: begin
            // Only the right shifts look at funct7
            if (funct3 != 3'b101 || funct7 == funct7_zero || funct7 == funct7_alt) begin
                w.alu_op  = alu_for_funct3(funct3, funct3 == 3'b101 && funct7 == funct7_alt);
                w.op2_sel = op2_imm; // Upper bits are immediate for non-shifts
                w.rf_we   = 1'b1;
                w.wb_sel  = wb_alu;
            end
        end
        op_load: begin
            if (funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) begin
                w.op2_sel   = op2_imm;
                w.rf_we     = 1'b1;
                w.mem_en    = 1'b1;
                w.wb_sel    = wb_mem;
                w.mem_width = mem_width_e'(funct3); // Width code is funct3
            end
        end
        op_store: begin
            if (funct3 inside {3'd0, 3'd1, 3'd2}) begin
                w.op2_sel   = op2_store_imm;
                w.mem_en    = 1'b1;
                w.mem_wen   = 1'b1;
                w.mem_width = mem_width_e'(funct3);
            end
        end
        op_branch: begin
            if (funct3 inside {3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7}) begin
                case (funct3[2:1])
                    2'b00:   taken = br.eq;
                    2'b10:   taken = br.lt;
                    default: taken = br.ltu;
                endcase
                if (funct3[0]) begin
                    taken = !taken; // Odd funct3 is the negated test
                end
                w.pc_sel = taken ? pc_branch : pc_seq;
                w.wb_sel = wb_alu;
            end
        end
        op_jal: begin
            w.pc_sel = pc_jal;
            w.rf_we  = 1'b1;
            w.wb_sel = wb_pc4; // Link address
        end
        op_jalr: begin
            if (funct3 == 3'b000) begin
                w.op2_sel = op2_imm;
                w.pc_sel  = pc_jalr;
                w.rf_we   = 1'b1;
                w.wb_sel  = wb_pc4;
            end
        end
        op_auipc: begin
            w.op1_sel = op1_pc;
            w.rf_we   = 1'b1;
            w.wb_sel  = wb_alu;
        end
        op_lui: begin
            w.alu_op  = alu_lui;
            w.op1_sel = op1_pc;
            w.rf_we   = 1'b1;
            w.wb_sel  = wb_alu;
        end
        default: begin
            w = '0;
        end
    endcase
    return w;
endfunction

`endif

// File: bench/ctrl_decode_tb.sv
// Testbench for the registered RV32I control decoder, LFSR instructions checked against a model
`timescale 1ns/1ps

module ctrl_decode_tb import rv32_ctrl_pkg::*; ();

    localparam int num_vectors = 3000;
    localparam int clk_period  = 100;                              // ns
    localparam int watchdog_ns = (num_vectors + 20) * clk_period;  // Vectors plus 20 cycles

    logic              clk;
    logic              rst;
    logic              in_valid;
    logic [inst_w-1:0] inst;
    br_flags_t         br;
    logic              out_valid;
    ctrl_word_t        ctrl;

    logic [31:0] lfsr_state;   // Fibonacci LFSR
    logic        exp_valid_q [$];
    ctrl_word_t  exp_ctrl_q [$];
    ctrl_word_t  held_ctrl;    // Model of the output register
    int          error_count;

    `include "ctrl_ref_model.svh"

    ctrl_decode_top ctrl_decode_top_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .inst      (inst),
        .br        (br),
        .out_valid (out_valid),
        .ctrl      (ctrl)
    );

    always #(clk_period / 2) clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_step();
        logic fb;
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // Table template with random register and immediate fields
    function automatic logic [31:0] random_inst();
        logic [31:0] raw;
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [2:0]  twist;
        int unsigned cat;
        raw = rand_bits(32);
        f3  = raw[14:12];
        f7  = raw[31:25];
        cat = rand_bits(4) % 10;
        case (cat)
            0: begin
                op = op_reg;
                f7 = rand_bits(1) ? funct7_alt : funct7_zero; // Alt on non-sub/sra misses
            end
            1: begin
                op = op_imm;
                if (f3 == 3'b001) begin
                    f7 = funct7_zero;
                end else if (f3 == 3'b101) begin
                    f7 = rand_bits(1) ? funct7_alt : funct7_zero;
                end
            end
            2: begin
                op = op_load;
                case (f3)
                    3'd3:    f3 = 3'd4; // Fold unused codes onto loads
                    3'd6:    f3 = 3'd5;
                    3'd7:    f3 = 3'd2;
                    default: f3 = f3;
                endcase
            end
            3: begin
                op = op_store;
                f3 = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
            end
            4: begin
                op = op_branch;
                if (f3[2:1] == 2'b01) begin
                    f3[2] = 1'b1; // 2 and 3 become bltu and bgeu
                end
            end
            5: op = op_jal;
            6: begin
                op = op_jalr;
                f3 = 3'b000;
            end
            7: op = op_lui;
            8: op = op_auipc;
            default: op = 7'(rand_bits(7)); // Mostly unknown opcodes
        endcase
        twist = 3'(rand_bits(3));
        if (twist == 3'd0) begin
            f7 = 7'(rand_bits(7));
        end else if (twist == 3'd1) begin
            f3 = 3'(rand_bits(3));
        end
        return {f7, raw[24:15], f3, raw[11:7], op};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired, decoder run did not finish in %0d ns", watchdog_ns);
        $display("Simulation failed");
        $fatal(1, "Timeout");
    end

    initial begin
        logic       exp_valid;
        ctrl_word_t exp_ctrl;
        lfsr_state  = 32'h5806_d57c;
        clk         = 1'b0;
        rst         = 1'b1;
        in_valid    = 1'b0;
        inst        = '0;
        br          = '0;
        held_ctrl   = '0;
        error_count = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("out_valid", {31'd0, out_valid}, 32'd0); // Cleared by reset
        check_value("ctrl", {12'd0, ctrl}, 32'd0);
        for (int n = 0; n < num_vectors; n++) begin
            in_valid = (rand_bits(2) != 0); // About 3 in 4 valid
            inst     = random_inst();
            br       = 3'(rand_bits(3));
            if (in_valid) begin
                held_ctrl = expected_ctrl(inst, br);
            end
            exp_valid_q.push_back(in_valid);
            exp_ctrl_q.push_back(held_ctrl);
            @(posedge clk);
            #1;
            exp_valid = exp_valid_q.pop_front();
            exp_ctrl  = exp_ctrl_q.pop_front();
            check_value("out_valid", {31'd0, out_valid}, {31'd0, exp_valid});
            check_value("ctrl", {12'd0, ctrl}, {12'd0, exp_ctrl});
        end
        if (error_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "%0d mismatches", error_count);
        end
    end

endmodule

// File: filelist.f
+incdir+bench
logic/rv32_ctrl_pkg.sv
logic/inst_key_former.sv
logic/ctrl_lut.sv
logic/branch_resolve.sv
logic/ctrl_decode_top.sv
bench/ctrl_decode_tb.sv

// File: Makefile
# Verilator build and run of the RV32I control decoder testbench

VERILATOR ?= verilator
TOP       ?= ctrl_decode_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= Simulation completed successfully

SOURCES  := $(shell grep -v '^+' $(FILELIST))
INCLUDES := $(wildcard bench/*.svh)
BIN      := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

$(BIN): $(SOURCES) $(INCLUDES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
